// ==== design/memNetPkg.sv ====
package memNetPkg;

    ////////////////////////////////////////////////////////////////////////////
    // memory operations carried on the CPU port and in network packets.
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        opIdle,
        opLoadReq,
        opLoadDone,
        opStoreReq,
        opStoreDone
    } memOp;

    ////////////////////////////////////////////////////////////////////////////
    // network geometry and packet layout.
    ////////////////////////////////////////////////////////////////////////////

    localparam int nodeCount   = 2;
    localparam int nodeIdWidth = 1;
    localparam int dataWidth   = 32;

    // upper half carries data, lower half the address or slice offset.
    localparam int packetWidth = 64;

    // filler for the unused fields of a reply packet.
    localparam logic [dataWidth-1:0] replyFill = '1;

endpackage

// ==== design/localRam.sv ====
`timescale 1ns/1ps

module localRam
    import memNetPkg::*;
#(
    parameter int ramChunkSize = 256
) (
    input  logic                            clk,
    input  logic [$clog2(ramChunkSize)-1:0] address,
    input  logic [dataWidth-1:0]            writeData,
    input  logic                            we,
    output logic [dataWidth-1:0]            readData
);

    logic [dataWidth-1:0] mem [ramChunkSize];

    // a read in the write cycle returns the old word.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[address] <= writeData;
        end
        readData <= mem[address];
    end

    // the controller must never write outside this node's slice.
    assert property (@(posedge clk) we |-> address < ramChunkSize);

endmodule

// ==== design/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl
    import memNetPkg::*;
#(
    parameter int ramChunkSize  = 256,
    parameter int packetIdWidth = 5,
    parameter int ttl           = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [dataWidth-1:0]            memData,
    input  logic [dataWidth-1:0]            memAddress,
    input  memOp                            memInstr,
    output logic [dataWidth-1:0]            dataToCpu,
    output logic                            instrSuccess,

    input  logic [dataWidth-1:0]            rdData,
    output logic [$clog2(ramChunkSize)-1:0] ramAddress,
    output logic [dataWidth-1:0]            wrData,
    output logic                            we,

    input  logic [packetWidth-1:0]          packetIn,
    input  memOp                            instrIn,
    input  logic [nodeIdWidth-1:0]          nodeStart,
    input  logic                            validIn,
    output logic                            readyToReceive,

    output logic [packetWidth-1:0]          packetOut,
    output memOp                            instrOut,
    output logic [nodeIdWidth-1:0]          nodeDest,
    output logic [packetIdWidth-1:0]        packetId,
    output logic                            validOut,
    input  logic                            splitterReady
);

    localparam int offsetWidth = $clog2(ramChunkSize);
    localparam int timerWidth  = $clog2(ttl + 1);

    logic [1:0]             counter;
    logic [packetWidth-1:0] packetInReg;
    memOp                   instrInReg;
    logic [nodeIdWidth-1:0] sourceReg;
    logic                   busy;
    logic [timerWidth-1:0]  timer;

    logic                   idle;
    logic                   outFree;
    logic                   issueNow;
    logic                   retryNow;
    logic                   loadServe;
    logic                   storeServe;
    logic                   storeNow;
    logic                   replyNow;
    logic                   doneNow;
    logic [nodeIdWidth-1:0] cpuNode;
    logic [dataWidth-1:0]   cpuOffset;

    ////////////////////////////////////////////////////////////////////////////
    // decode.
    ////////////////////////////////////////////////////////////////////////////

    assign idle           = counter == 2'd0;
    assign readyToReceive = idle;

    // the output register can take a new packet once the old one is gone.
    assign outFree = !validOut || splitterReady;

    assign issueNow = idle && outFree && memInstr != opIdle && !busy;
    assign retryNow = idle && outFree && memInstr != opIdle && busy && timer == ttl;

    assign loadServe  = instrInReg == opLoadReq;
    assign storeServe = instrInReg == opStoreReq;
    assign storeNow   = counter == 2'd1 && storeServe && outFree;
    assign replyNow   = outFree && ((counter == 2'd1 && storeServe) || counter == 2'd3);
    assign doneNow    = counter == 2'd1 &&
                        (instrInReg == opLoadDone || instrInReg == opStoreDone);

    // home node and slice offset of the CPU address.
    assign cpuNode   = nodeIdWidth'(memAddress / ramChunkSize);
    assign cpuOffset = dataWidth'(memAddress % ramChunkSize);

    ////////////////////////////////////////////////////////////////////////////
    // sequencer and request tracking.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter      <= 2'd0;
            validOut     <= 1'b0;
            instrSuccess <= 1'b0;
            we           <= 1'b0;
            busy         <= 1'b0;
            timer        <= '0;
            packetId     <= '0;
        end else begin
            instrSuccess <= doneNow;
            we           <= storeNow;

            if (validOut && splitterReady) begin
                validOut <= 1'b0;
            end
            if (issueNow || retryNow || replyNow) begin
                validOut <= 1'b1;
            end
            // a retry keeps the id of the original request.
            if (issueNow || replyNow) begin
                packetId <= packetId + 1'b1;
            end

            if (issueNow) begin
                busy <= 1'b1;
            end else if (instrSuccess) begin
                busy <= 1'b0;
            end

            if (issueNow || retryNow || !busy) begin
                timer <= '0;
            end else if (timer != ttl) begin
                timer <= timer + 1'b1;
            end

            // load walks 1 -> 2 -> 3, store and replies finish in 1.
            unique case (counter)
                2'd0: if (validIn) counter <= 2'd1;
                2'd1: begin
                    if (loadServe) begin
                        counter <= 2'd2;
                    end else if (!storeServe || outFree) begin
                        counter <= 2'd0;
                    end
                end
                2'd2: counter <= 2'd3;
                2'd3: if (outFree) counter <= 2'd0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet and RAM payload.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (idle && validIn) begin
            packetInReg <= packetIn;
            instrInReg  <= instrIn;
            sourceReg   <= nodeStart;
        end
        if (counter == 2'd1) begin
            ramAddress <= packetInReg[offsetWidth-1:0];
            wrData     <= packetInReg[packetWidth-1:dataWidth];
        end
        if (doneNow) begin
            dataToCpu <= packetInReg[packetWidth-1:dataWidth];
        end

        if (issueNow || retryNow) begin
            packetOut <= {memData, cpuOffset};
            instrOut  <= memInstr;
            nodeDest  <= cpuNode;
        end else if (replyNow) begin
            packetOut <= {(counter == 2'd3) ? rdData : replyFill, replyFill};
            instrOut  <= storeServe ? opStoreDone : opLoadDone;
            nodeDest  <= sourceReg;
        end
    end

    // the CPU holds its request steady until the success pulse.
    assert property (@(posedge clk) disable iff (!rst_n)
        memInstr != opIdle && !instrSuccess |=>
            instrSuccess || ($stable(memInstr) && $stable(memAddress)));

    // a packet offered while the controller is serving waits until it is taken.
    assert property (@(posedge clk) disable iff (!rst_n)
        validIn && !readyToReceive |=> validIn && $stable(packetIn) && $stable(instrIn));

endmodule

// ==== design/packetSwitch.sv ====
`timescale 1ns/1ps

module packetSwitch
    import memNetPkg::*;
#(
    parameter int packetIdWidth = 5
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [packetWidth-1:0]   inPacket0,
    input  memOp                     inInstr0,
    input  logic [nodeIdWidth-1:0]   inDest0,
    input  logic [packetIdWidth-1:0] inId0,
    input  logic                     inValid0,
    output logic                     inReady0,
    input  logic [packetWidth-1:0]   inPacket1,
    input  memOp                     inInstr1,
    input  logic [nodeIdWidth-1:0]   inDest1,
    input  logic [packetIdWidth-1:0] inId1,
    input  logic                     inValid1,
    output logic                     inReady1,

    output logic [packetWidth-1:0]   outPacket0,
    output memOp                     outInstr0,
    output logic [nodeIdWidth-1:0]   outSource0,
    output logic                     outValid0,
    input  logic                     outReady0,
    output logic [packetWidth-1:0]   outPacket1,
    output memOp                     outInstr1,
    output logic [nodeIdWidth-1:0]   outSource1,
    output logic                     outValid1,
    input  logic                     outReady1
);

    logic [packetWidth-1:0]   inPacket  [nodeCount];
    memOp                     inInstr   [nodeCount];
    logic [nodeIdWidth-1:0]   inDest    [nodeCount];
    logic [packetIdWidth-1:0] inId      [nodeCount];
    logic [nodeCount-1:0]     inValid;
    logic [nodeCount-1:0]     inReady;
    logic [packetWidth-1:0]   outPacket [nodeCount];
    memOp                     outInstr  [nodeCount];
    logic [nodeIdWidth-1:0]   outSource [nodeCount];
    logic                     outValid  [nodeCount];
    logic [nodeCount-1:0]     outReady;

    // grant[o][i] is set when output o takes input i this cycle.
    logic [nodeCount-1:0]     grant     [nodeCount];
    logic                     rrPtr     [nodeCount];

    assign inPacket = '{inPacket0, inPacket1};
    assign inInstr  = '{inInstr0, inInstr1};
    assign inDest   = '{inDest0, inDest1};
    assign inId     = '{inId0, inId1};
    assign inValid  = {inValid1, inValid0};
    assign outReady = {outReady1, outReady0};

    assign {inReady1, inReady0} = inReady;
    assign outPacket0 = outPacket[0];
    assign outInstr0  = outInstr[0];
    assign outSource0 = outSource[0];
    assign outValid0  = outValid[0];
    assign outPacket1 = outPacket[1];
    assign outInstr1  = outInstr[1];
    assign outSource1 = outSource[1];
    assign outValid1  = outValid[1];

    ////////////////////////////////////////////////////////////////////////////
    // one register stage and round-robin arbiter per output.
    ////////////////////////////////////////////////////////////////////////////

    for (genvar o = 0; o < nodeCount; o++) begin : g_out
        logic [nodeCount-1:0] req;
        logic                 stageFree;

        assign req[0]    = inValid[0] && inDest[0] == o;
        assign req[1]    = inValid[1] && inDest[1] == o;
        assign stageFree = !outValid[o] || outReady[o];

        always_comb begin
            grant[o] = '0;
            if (stageFree) begin
                if (req[0] && req[1]) begin
                    grant[o][rrPtr[o]] = 1'b1;
                end else begin
                    grant[o] = req;
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                outValid[o] <= 1'b0;
                rrPtr[o]    <= 1'b0;
            end else if (stageFree) begin
                outValid[o] <= |grant[o];
                if (req[0] && req[1]) begin
                    rrPtr[o] <= ~rrPtr[o];
                end
            end
        end

        // the source index rides along as the receiver's nodeStart.
        always_ff @(posedge clk) begin
            if (|grant[o]) begin
                outPacket[o] <= grant[o][1] ? inPacket[1] : inPacket[0];
                outInstr[o]  <= grant[o][1] ? inInstr[1] : inInstr[0];
                outSource[o] <= grant[o][1];
            end
        end

        assert property (@(posedge clk) disable iff (!rst_n)
            outValid[o] && !outReady[o] |=> outValid[o] && $stable(outPacket[o]));
    end

    for (genvar i = 0; i < nodeCount; i++) begin : g_in
        assign inReady[i] = grant[0][i] | grant[1][i];

        // a stalled source must hold the same packet until it is taken.
        assert property (@(posedge clk) disable iff (!rst_n)
            inValid[i] && !inReady[i] |=> $stable(inId[i]) && $stable(inPacket[i]));
    end

    assert property (@(posedge clk) disable iff (!rst_n) (grant[0] & grant[1]) == '0);

endmodule

// ==== design/memNet.sv ====
`timescale 1ns/1ps

module memNet
    import memNetPkg::*;
#(
    parameter int ramChunkSize  = 256,
    parameter int packetIdWidth = 5,
    parameter int ttl           = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [dataWidth-1:0] memData0,
    input  logic [dataWidth-1:0] memAddress0,
    input  memOp                 memInstr0,
    output logic [dataWidth-1:0] dataToCpu0,
    output logic                 instrSuccess0,
    input  logic [dataWidth-1:0] memData1,
    input  logic [dataWidth-1:0] memAddress1,
    input  memOp                 memInstr1,
    output logic [dataWidth-1:0] dataToCpu1,
    output logic                 instrSuccess1
);

    localparam int offsetWidth = $clog2(ramChunkSize);

    logic [dataWidth-1:0]     cpuData    [nodeCount];
    logic [dataWidth-1:0]     cpuAddress [nodeCount];
    memOp                     cpuInstr   [nodeCount];
    logic [dataWidth-1:0]     cpuResult  [nodeCount];
    logic                     cpuSuccess [nodeCount];

    logic [offsetWidth-1:0]   ramAddr    [nodeCount];
    logic [dataWidth-1:0]     ramWrData  [nodeCount];
    logic [dataWidth-1:0]     ramRdData  [nodeCount];
    logic                     ramWe      [nodeCount];

    logic [packetWidth-1:0]   txPacket   [nodeCount];
    memOp                     txInstr    [nodeCount];
    logic [nodeIdWidth-1:0]   txDest     [nodeCount];
    logic [packetIdWidth-1:0] txId       [nodeCount];
    logic                     txValid    [nodeCount];
    logic                     txReady    [nodeCount];
    logic [packetWidth-1:0]   rxPacket   [nodeCount];
    memOp                     rxInstr    [nodeCount];
    logic [nodeIdWidth-1:0]   rxSource   [nodeCount];
    logic                     rxValid    [nodeCount];
    logic                     rxReady    [nodeCount];

    assign cpuData    = '{memData0, memData1};
    assign cpuAddress = '{memAddress0, memAddress1};
    assign cpuInstr   = '{memInstr0, memInstr1};
    assign dataToCpu0    = cpuResult[0];
    assign instrSuccess0 = cpuSuccess[0];
    assign dataToCpu1    = cpuResult[1];
    assign instrSuccess1 = cpuSuccess[1];

    for (genvar n = 0; n < nodeCount; n++) begin : g_node
        memCtrl #(
            .ramChunkSize (ramChunkSize),
            .packetIdWidth(packetIdWidth),
            .ttl          (ttl)
        ) ctrl (
            .clk           (clk),
            .rst_n         (rst_n),
            .memData       (cpuData[n]),
            .memAddress    (cpuAddress[n]),
            .memInstr      (cpuInstr[n]),
            .dataToCpu     (cpuResult[n]),
            .instrSuccess  (cpuSuccess[n]),
            .rdData        (ramRdData[n]),
            .ramAddress    (ramAddr[n]),
            .wrData        (ramWrData[n]),
            .we            (ramWe[n]),
            .packetIn      (rxPacket[n]),
            .instrIn       (rxInstr[n]),
            .nodeStart     (rxSource[n]),
            .validIn       (rxValid[n]),
            .readyToReceive(rxReady[n]),
            .packetOut     (txPacket[n]),
            .instrOut      (txInstr[n]),
            .nodeDest      (txDest[n]),
            .packetId      (txId[n]),
            .validOut      (txValid[n]),
            .splitterReady (txReady[n])
        );

        localRam #(.ramChunkSize(ramChunkSize)) ram (
            .clk      (clk),
            .address  (ramAddr[n]),
            .writeData(ramWrData[n]),
            .we       (ramWe[n]),
            .readData (ramRdData[n])
        );
    end

    packetSwitch #(.packetIdWidth(packetIdWidth)) netSwitch (
        .clk       (clk),
        .rst_n     (rst_n),
        .inPacket0 (txPacket[0]),
        .inInstr0  (txInstr[0]),
        .inDest0   (txDest[0]),
        .inId0     (txId[0]),
        .inValid0  (txValid[0]),
        .inReady0  (txReady[0]),
        .inPacket1 (txPacket[1]),
        .inInstr1  (txInstr[1]),
        .inDest1   (txDest[1]),
        .inId1     (txId[1]),
        .inValid1  (txValid[1]),
        .inReady1  (txReady[1]),
        .outPacket0(rxPacket[0]),
        .outInstr0 (rxInstr[0]),
        .outSource0(rxSource[0]),
        .outValid0 (rxValid[0]),
        .outReady0 (rxReady[0]),
        .outPacket1(rxPacket[1]),
        .outInstr1 (rxInstr[1]),
        .outSource1(rxSource[1]),
        .outValid1 (rxValid[1]),
        .outReady1 (rxReady[1])
    );

endmodule

// ==== verif/memNetModel.svh ====
`ifndef MEM_NET_MODEL_SVH
`define MEM_NET_MODEL_SVH

// reference copy of both slices, indexed by the global word address.
logic [dataWidth-1:0] modelMem     [nodeCount*chunkWords];
bit                   modelWritten [nodeCount*chunkWords];

logic [31:0]          lcgState = 32'h668b0681;

// 32-bit LCG whose upper bits are the most random.
function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

// global address of a word from its home node and slice offset.
function automatic logic [dataWidth-1:0] globalAddress(input int node, input int offset);
    return dataWidth'(node * chunkWords + offset);
endfunction

function automatic void modelWrite(input logic [dataWidth-1:0] address,
                                   input logic [dataWidth-1:0] data);
    modelMem[address]     = data;
    modelWritten[address] = 1'b1;
endfunction

// value a load of this address must return.
function automatic logic [dataWidth-1:0] modelRead(input logic [dataWidth-1:0] address);
    return modelMem[address];
endfunction

function automatic bit modelHolds(input logic [dataWidth-1:0] address);
    return modelWritten[address];
endfunction

`endif

// ==== verif/memNetTb.sv ====
`timescale 1ns/1ps

module memNetTb
    import memNetPkg::*;
();

    localparam int chunkWords  = 32;
    localparam int ttlCycles   = 1000;
    localparam int periodNs    = 100;
    localparam int resetCycles = 10;
    localparam int idleCycles  = 20;
    localparam int randomOps   = 200;
    localparam int opBound     = 40;
    localparam int opCount     = 14 + randomOps;

    logic                 clk;
    logic                 rst_n;
    logic [dataWidth-1:0] memData0;
    logic [dataWidth-1:0] memAddress0;
    memOp                 memInstr0;
    logic [dataWidth-1:0] dataToCpu0;
    logic                 instrSuccess0;
    logic [dataWidth-1:0] memData1;
    logic [dataWidth-1:0] memAddress1;
    memOp                 memInstr1;
    logic [dataWidth-1:0] dataToCpu1;
    logic                 instrSuccess1;
    int                   checkCount;

    `include "memNetModel.svh"

    memNet #(
        .ramChunkSize (chunkWords),
        .packetIdWidth(5),
        .ttl          (ttlCycles)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .memData0     (memData0),
        .memAddress0  (memAddress0),
        .memInstr0    (memInstr0),
        .dataToCpu0   (dataToCpu0),
        .instrSuccess0(instrSuccess0),
        .memData1     (memData1),
        .memAddress1  (memAddress1),
        .memInstr1    (memInstr1),
        .dataToCpu1   (dataToCpu1),
        .instrSuccess1(instrSuccess1)
    );

    always #(periodNs / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // present one request and hold it until the CPU port reports success.
    task automatic issueAndWait(input int cpu, input memOp op,
                                input logic [dataWidth-1:0] address,
                                input logic [dataWidth-1:0] data,
                                output logic [dataWidth-1:0] result);
        @(negedge clk);
        if (cpu == 0) begin
            memInstr0   = op;
            memAddress0 = address;
            memData0    = data;
        end else begin
            memInstr1   = op;
            memAddress1 = address;
            memData1    = data;
        end
        do begin
            @(negedge clk);
        end while (!((cpu == 0) ? instrSuccess0 : instrSuccess1));
        result = (cpu == 0) ? dataToCpu0 : dataToCpu1;
        if (cpu == 0) begin
            memInstr0 = opIdle;
        end else begin
            memInstr1 = opIdle;
        end
        @(negedge clk);
    endtask

    task automatic storeWord(input int cpu,
                             input logic [dataWidth-1:0] address,
                             input logic [dataWidth-1:0] data);
        logic [dataWidth-1:0] unused;
        modelWrite(address, data);
        issueAndWait(cpu, opStoreReq, address, data, unused);
    endtask

    task automatic loadWord(input string name, input int cpu,
                            input logic [dataWidth-1:0] address);
        logic [dataWidth-1:0] expected;
        logic [dataWidth-1:0] result;
        expected = modelRead(address);
        issueAndWait(cpu, opLoadReq, address, '0, result);
        checkValue(name, expected, result);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [dataWidth-1:0] address;
        logic [dataWidth-1:0] data;
        logic [dataWidth-1:0] otherData;
        logic [31:0]          r;
        int                   cpu;
        clk         = 1'b0;
        rst_n       = 1'b0;
        memData0    = '0;
        memAddress0 = '0;
        memInstr0   = opIdle;
        memData1    = '0;
        memAddress1 = '0;
        memInstr1   = opIdle;
        checkCount  = 0;
        repeat (resetCycles) @(negedge clk);
        rst_n = 1'b1;

        repeat (idleCycles) begin
            @(negedge clk);
            checkValue("reset idle cpu0", '0, instrSuccess0);
            checkValue("reset idle cpu1", '0, instrSuccess1);
        end

        for (int i = 0; i < 4; i++) begin
            address = globalAddress(0, (nextRandom() >> 16) % chunkWords);
            storeWord(0, address, nextRandom());
            loadWord("local load", 0, address);
        end

        // CPU1 writes into node 0, CPU0 reads it back.
        address = globalAddress(0, 5);
        storeWord(1, address, nextRandom());
        loadWord("cross node load", 0, address);

        // both CPUs hit node 1 in the same cycle.
        data      = nextRandom();
        otherData = nextRandom();
        fork
            storeWord(0, globalAddress(1, 10), data);
            storeWord(1, globalAddress(1, 11), otherData);
        join
        fork
            loadWord("contention load cpu0", 0, globalAddress(1, 11));
            loadWord("contention load cpu1", 1, globalAddress(1, 10));
        join

        for (int i = 0; i < randomOps; i++) begin
            r       = nextRandom();
            cpu     = r[31];
            address = (r >> 8) % (nodeCount * chunkWords);
            data    = nextRandom();
            // a word never written has no known value, so it gets a store.
            if (r[30] && modelHolds(address)) begin
                loadWord("random load", cpu, address);
            end else begin
                storeWord(cpu, address, data);
            end
        end

        $display("%0d checks done", checkCount);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #((resetCycles + idleCycles + opCount * opBound) * periodNs);
        $display("timeout: operations did not complete within %0d cycles",
                 resetCycles + idleCycles + opCount * opBound);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
+incdir+verif
design/memNetPkg.sv
design/localRam.sv
design/memCtrl.sv
design/packetSwitch.sv
design/memNet.sv
verif/memNetTb.sv
